/* sim.f */
rtl/shell_pkg.sv
rtl/sleep_ctrl.sv
rtl/register_file.sv
rtl/scramble_key_ctrl.sv
rtl/scr_ram_1p.sv
rtl/core_shell_top.sv
testbench/tb_core_shell.sv

/* Bender.yml */
package:
  name: core_shell

sources:
  # Package first, then leaf modules, then the top level
  - rtl/shell_pkg.sv
  - rtl/sleep_ctrl.sv
  - rtl/register_file.sv
  - rtl/scramble_key_ctrl.sv
  - rtl/scr_ram_1p.sv
  - rtl/core_shell_top.sv

  - target: simulation
    files:
      - testbench/tb_core_shell.sv

/* testbench/tb_core_shell.sv */
////////////////////////////////////////////////////////////////////////////
// Directed testbench for core_shell_top with SecureBusy set and Rv32e clear
// Plays the part of the core and keeps test_en_i low throughout
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_core_shell import shell_pkg::*; ();

  localparam int unsigned ResetCycles = 8;
  localparam int unsigned RfWrites    = 8;
  localparam int unsigned CacheLines  = 4;
  // Summed cycle budget of all tests
  localparam int unsigned TestCycles  = ResetCycles + 18 + (RfWrites + 3) * 4
                                        + IcNumWays * CacheLines * 10 + 8;
  // Watchdog allows twice the budget
  localparam int unsigned TimeoutNs   = 2 * TestCycles * 40;

  logic clk_i = 1'b0;
  logic rst_ni, test_en_i;
  busy_code_t core_busy_i;
  logic irq_pending_i, irq_nm_i, debug_req_i, core_sleep_o;
  logic [RfAddrW-1:0] rf_raddr_a_i, rf_raddr_b_i, rf_waddr_i;
  logic rf_we_i;
  logic [RfDataW-1:0] rf_wdata_i, rf_rdata_a_o, rf_rdata_b_o;
  logic ic_scr_key_req_i, ic_scr_key_valid_o, scramble_key_valid_i, scramble_req_o;
  logic [ScrKeyW-1:0] scramble_key_i;
  logic [IcNumWays-1:0] ic_tag_req_i, ic_data_req_i;
  logic ic_tag_write_i, ic_data_write_i;
  logic [IcIndexW-1:0] ic_tag_addr_i, ic_data_addr_i;
  logic [IcTagW-1:0] ic_tag_wdata_i;
  logic [IcLineW-1:0] ic_data_wdata_i;
  logic [IcNumWays-1:0][IcTagW-1:0] ic_tag_rdata_o;
  logic [IcNumWays-1:0][IcLineW-1:0] ic_data_rdata_o;

  // Reference state kept by the testbench
  int unsigned error_count = 0;
  int seed = 52374;
  logic [RfDataW-1:0] rf_model [2**RfAddrW] = '{default: '0};
  logic [IcTagW-1:0] tag_written [IcNumWays][CacheLines];
  logic [IcLineW-1:0] line_written [IcNumWays][CacheLines];
  logic [ScrKeyW-1:0] key_now = ScrKeyDefault;
  logic [ScrKeyW-1:0] key_at_write;

  core_shell_top #(
    .SecureBusy(1'b1),
    .Rv32e     (1'b0)
  ) uut (.*);

  always #20 clk_i = ~clk_i;

  ////////////////////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic compare_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      error_count++;
      $display("ERROR at %0t ns: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic compare_rf_word(input logic [RfDataW-1:0] got,
                                 input logic [RfDataW-1:0] exp, input string what);
    if (got !== exp) begin
      error_count++;
      $display("ERROR at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic compare_tag(input logic [IcTagW-1:0] got,
                             input logic [IcTagW-1:0] exp, input string what);
    if (got !== exp) begin
      error_count++;
      $display("ERROR at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic compare_line(input logic [IcLineW-1:0] got,
                              input logic [IcLineW-1:0] exp, input string what);
    if (got !== exp) begin
      error_count++;
      $display("ERROR at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Bus helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic write_reg(input logic [RfAddrW-1:0] addr, input logic [RfDataW-1:0] data);
    @(posedge clk_i);
    rf_we_i    <= 1'b1;
    rf_waddr_i <= addr;
    rf_wdata_i <= data;
    @(posedge clk_i);
    rf_we_i    <= 1'b0;
  endtask

  task automatic check_reg(input logic [RfAddrW-1:0] addr, input logic [RfDataW-1:0] exp);
    @(posedge clk_i);
    rf_raddr_a_i <= addr;
    rf_raddr_b_i <= addr;
    @(negedge clk_i);
    compare_rf_word(rf_rdata_a_o, exp, $sformatf("read port a, x%0d", addr));
    compare_rf_word(rf_rdata_b_o, exp, $sformatf("read port b, x%0d", addr));
  endtask

  task automatic write_cache(input int way, input logic [IcIndexW-1:0] addr,
                             input logic [IcTagW-1:0] tag, input logic [IcLineW-1:0] line);
    @(posedge clk_i);
    ic_tag_req_i    <= IcNumWays'(1 << way);
    ic_data_req_i   <= IcNumWays'(1 << way);
    ic_tag_write_i  <= 1'b1;
    ic_data_write_i <= 1'b1;
    ic_tag_addr_i   <= addr;
    ic_data_addr_i  <= addr;
    ic_tag_wdata_i  <= tag;
    ic_data_wdata_i <= line;
    @(posedge clk_i);
    ic_tag_req_i    <= '0;
    ic_data_req_i   <= '0;
  endtask

  // Read result is due one cycle after the request and must then hold
  task automatic check_cache(input int way, input logic [IcIndexW-1:0] addr,
                             input logic [IcTagW-1:0] exp_tag,
                             input logic [IcLineW-1:0] exp_line);
    @(posedge clk_i);
    ic_tag_req_i    <= IcNumWays'(1 << way);
    ic_data_req_i   <= IcNumWays'(1 << way);
    ic_tag_write_i  <= 1'b0;
    ic_data_write_i <= 1'b0;
    ic_tag_addr_i   <= addr;
    ic_data_addr_i  <= addr;
    @(posedge clk_i);
    ic_tag_req_i    <= '0;
    ic_data_req_i   <= '0;
    repeat (2) begin
      @(negedge clk_i);
      compare_tag(ic_tag_rdata_o[way], exp_tag, $sformatf("tag way %0d line %0d", way, addr));
      compare_line(ic_data_rdata_o[way], exp_line,
                   $sformatf("data way %0d line %0d", way, addr));
    end
  endtask

  function automatic logic [IcIndexW-1:0] line_index(input int i);
    return IcIndexW'(i * 13 + 5);
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic test_reset_state();
    @(negedge clk_i);
    compare_bit(core_sleep_o, 1'b1, "core_sleep_o after reset");
    compare_bit(scramble_req_o, 1'b0, "scramble_req_o after reset");
    compare_bit(ic_scr_key_valid_o, 1'b1, "ic_scr_key_valid_o after reset");
  endtask

  task automatic test_sleep_wake();
    @(posedge clk_i);
    core_busy_i <= BusyOn;
    @(negedge clk_i);
    compare_bit(core_sleep_o, 1'b1, "core_sleep_o before BusyOn is registered");
    @(negedge clk_i);
    compare_bit(core_sleep_o, 1'b0, "core_sleep_o one cycle after BusyOn");
    @(posedge clk_i);
    core_busy_i <= BusyOff;
    @(negedge clk_i);
    compare_bit(core_sleep_o, 1'b0, "core_sleep_o before BusyOff is registered");
    @(negedge clk_i);
    compare_bit(core_sleep_o, 1'b1, "core_sleep_o one cycle after BusyOff");
    // Any code other than BusyOff counts as busy
    @(posedge clk_i);
    core_busy_i <= 4'b0000;
    repeat (2) @(negedge clk_i);
    compare_bit(core_sleep_o, 1'b0, "core_sleep_o with busy code 0000");
    @(posedge clk_i);
    core_busy_i <= BusyOff;
    repeat (2) @(negedge clk_i);
    @(posedge clk_i);
    irq_nm_i <= 1'b1;
    @(negedge clk_i);
    compare_bit(core_sleep_o, 1'b0, "core_sleep_o with irq_nm_i high");
    @(posedge clk_i);
    irq_nm_i    <= 1'b0;
    debug_req_i <= 1'b1;
    @(negedge clk_i);
    compare_bit(core_sleep_o, 1'b0, "core_sleep_o with debug_req_i high");
    @(posedge clk_i);
    debug_req_i   <= 1'b0;
    irq_pending_i <= 1'b1;
    @(negedge clk_i);
    compare_bit(core_sleep_o, 1'b0, "core_sleep_o with irq_pending_i high");
    @(posedge clk_i);
    irq_pending_i <= 1'b0;
    @(negedge clk_i);
    compare_bit(core_sleep_o, 1'b1, "core_sleep_o after wake events drop");
  endtask

  task automatic test_register_file();
    logic [RfAddrW-1:0] addr;
    logic [RfDataW-1:0] data;
    @(posedge clk_i);
    core_busy_i <= BusyOn;
    repeat (2) @(posedge clk_i);
    // First pass hits x0 and must leave it zero
    for (int i = 0; i <= RfWrites; i++) begin
      addr = (i == 0) ? '0 : RfAddrW'(i * 3 + 1);
      data = $random(seed);
      write_reg(addr, data);
      if (addr != '0) begin
        rf_model[addr] = data;
      end
      check_reg(addr, rf_model[addr]);
    end
    // Writes are lost while the gated clock is stopped
    @(posedge clk_i);
    core_busy_i <= BusyOff;
    repeat (2) @(posedge clk_i);
    write_reg(RfAddrW'(4), $random(seed));
    check_reg(RfAddrW'(4), rf_model[4]);
  endtask

  task automatic test_cache_ram();
    key_at_write = key_now;
    for (int way = 0; way < IcNumWays; way++) begin
      for (int i = 0; i < CacheLines; i++) begin
        tag_written[way][i]  = IcTagW'($random(seed));
        line_written[way][i] = {$random(seed), $random(seed)};
        write_cache(way, line_index(i), tag_written[way][i], line_written[way][i]);
      end
    end
    for (int way = 0; way < IcNumWays; way++) begin
      for (int i = 0; i < CacheLines; i++) begin
        check_cache(way, line_index(i), tag_written[way][i], line_written[way][i]);
      end
    end
  endtask

  task automatic test_key_handshake();
    logic [ScrKeyW-1:0] new_key;
    new_key = {$random(seed), $random(seed)};
    @(posedge clk_i);
    ic_scr_key_req_i <= 1'b1;
    @(posedge clk_i);
    ic_scr_key_req_i <= 1'b0;
    @(negedge clk_i);
    compare_bit(scramble_req_o, 1'b1, "scramble_req_o after key request");
    compare_bit(ic_scr_key_valid_o, 1'b0, "ic_scr_key_valid_o after key request");
    @(posedge clk_i);
    scramble_key_valid_i <= 1'b1;
    scramble_key_i       <= new_key;
    @(negedge clk_i);
    compare_bit(ic_scr_key_valid_o, 1'b0, "ic_scr_key_valid_o before valid is seen");
    @(posedge clk_i);
    scramble_key_valid_i <= 1'b0;
    @(negedge clk_i);
    compare_bit(ic_scr_key_valid_o, 1'b1, "ic_scr_key_valid_o after key arrives");
    compare_bit(scramble_req_o, 1'b0, "scramble_req_o after key arrives");
    key_now = new_key;
  endtask

  // Old contents now descramble with the wrong key
  task automatic test_cache_rekey();
    logic [ScrKeyW-1:0] key_diff;
    key_diff = key_at_write ^ key_now;
    for (int way = 0; way < IcNumWays; way++) begin
      for (int i = 0; i < CacheLines; i++) begin
        check_cache(way, line_index(i), tag_written[way][i] ^ key_diff[IcTagW-1:0],
                    line_written[way][i] ^ key_diff[IcLineW-1:0]);
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence and watchdog
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    rst_ni               = 1'b0;
    test_en_i            = 1'b0;
    core_busy_i          = BusyOff;
    irq_pending_i        = 1'b0;
    irq_nm_i             = 1'b0;
    debug_req_i          = 1'b0;
    rf_raddr_a_i         = '0;
    rf_raddr_b_i         = '0;
    rf_waddr_i           = '0;
    rf_we_i              = 1'b0;
    rf_wdata_i           = '0;
    ic_scr_key_req_i     = 1'b0;
    scramble_key_valid_i = 1'b0;
    scramble_key_i       = '0;
    ic_tag_req_i         = '0;
    ic_tag_write_i       = 1'b0;
    ic_tag_addr_i        = '0;
    ic_tag_wdata_i       = '0;
    ic_data_req_i        = '0;
    ic_data_write_i      = 1'b0;
    ic_data_addr_i       = '0;
    ic_data_wdata_i      = '0;
    repeat (ResetCycles) @(posedge clk_i);
    rst_ni <= 1'b1;

    test_reset_state();
    test_sleep_wake();
    test_register_file();
    test_cache_ram();
    test_key_handshake();
    test_cache_rekey();

    $display("Run complete with %0d errors", error_count);
    if (error_count == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  initial begin
    #(TimeoutNs);
    $display("Watchdog expired: tests did not finish within %0d ns", TimeoutNs);
    $display("Errors found");
    $finish;
  end

endmodule

/* rtl/core_shell_top.sv */
////////////////////////////////////////////////////////////////////////////
// Wrapper around the core: clock gating, register file, key handshake
// and scrambled instruction cache RAMs, the core itself is external
// Cache RAMs run on the ungated clock
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module core_shell_top import shell_pkg::*; #(
  parameter bit SecureBusy = 1'b1,
  parameter bit Rv32e      = 1'b0
) (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic                                test_en_i,

  // Sleep control
  input  busy_code_t                          core_busy_i,
  input  logic                                irq_pending_i,
  input  logic                                irq_nm_i,
  input  logic                                debug_req_i,
  output logic                                core_sleep_o,

  // Register file
  input  logic [RfAddrW-1:0]                  rf_raddr_a_i,
  input  logic [RfAddrW-1:0]                  rf_raddr_b_i,
  input  logic [RfAddrW-1:0]                  rf_waddr_i,
  input  logic                                rf_we_i,
  input  logic [RfDataW-1:0]                  rf_wdata_i,
  output logic [RfDataW-1:0]                  rf_rdata_a_o,
  output logic [RfDataW-1:0]                  rf_rdata_b_o,

  // Scramble key
  input  logic                                ic_scr_key_req_i,
  output logic                                ic_scr_key_valid_o,
  input  logic                                scramble_key_valid_i,
  input  logic [ScrKeyW-1:0]                  scramble_key_i,
  output logic                                scramble_req_o,

  // Cache RAMs
  input  logic [IcNumWays-1:0]                ic_tag_req_i,
  input  logic                                ic_tag_write_i,
  input  logic [IcIndexW-1:0]                 ic_tag_addr_i,
  input  logic [IcTagW-1:0]                   ic_tag_wdata_i,
  output logic [IcNumWays-1:0][IcTagW-1:0]    ic_tag_rdata_o,
  input  logic [IcNumWays-1:0]                ic_data_req_i,
  input  logic                                ic_data_write_i,
  input  logic [IcIndexW-1:0]                 ic_data_addr_i,
  input  logic [IcLineW-1:0]                  ic_data_wdata_i,
  output logic [IcNumWays-1:0][IcLineW-1:0]   ic_data_rdata_o
);

  logic               clk_core;
  logic [ScrKeyW-1:0] scramble_key;

  sleep_ctrl #(
    .SecureBusy(SecureBusy)
  ) u_sleep_ctrl (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .test_en_i    (test_en_i),
    .core_busy_i  (core_busy_i),
    .irq_pending_i(irq_pending_i),
    .irq_nm_i     (irq_nm_i),
    .debug_req_i  (debug_req_i),
    .clk_core_o   (clk_core),
    .core_sleep_o (core_sleep_o)
  );

  // Register file sits in the gated clock domain
  register_file #(
    .Rv32e(Rv32e)
  ) u_register_file (
    .clk_i    (clk_core),
    .rst_ni   (rst_ni),
    .raddr_a_i(rf_raddr_a_i),
    .raddr_b_i(rf_raddr_b_i),
    .waddr_i  (rf_waddr_i),
    .we_i     (rf_we_i),
    .wdata_i  (rf_wdata_i),
    .rdata_a_o(rf_rdata_a_o),
    .rdata_b_o(rf_rdata_b_o)
  );

  scramble_key_ctrl u_scramble_key_ctrl (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .key_req_i     (ic_scr_key_req_i),
    .key_valid_i   (scramble_key_valid_i),
    .key_i         (scramble_key_i),
    .key_valid_o   (ic_scr_key_valid_o),
    .scramble_req_o(scramble_req_o),
    .key_o         (scramble_key)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Tag and data RAMs per way
  ////////////////////////////////////////////////////////////////////////////

  for (genvar way = 0; way < IcNumWays; way++) begin : g_ways
    scr_ram_1p #(
      .Width(IcTagW),
      .Depth(IcNumLines)
    ) u_tag_ram (
      .clk_i  (clk_i),
      .req_i  (ic_tag_req_i[way]),
      .write_i(ic_tag_write_i),
      .addr_i (ic_tag_addr_i),
      .wdata_i(ic_tag_wdata_i),
      .key_i  (scramble_key),
      .rdata_o(ic_tag_rdata_o[way])
    );

    scr_ram_1p #(
      .Width(IcLineW),
      .Depth(IcNumLines)
    ) u_data_ram (
      .clk_i  (clk_i),
      .req_i  (ic_data_req_i[way]),
      .write_i(ic_data_write_i),
      .addr_i (ic_data_addr_i),
      .wdata_i(ic_data_wdata_i),
      .key_i  (scramble_key),
      .rdata_o(ic_data_rdata_o[way])
    );
  end

endmodule

/* rtl/scr_ram_1p.sv */
////////////////////////////////////////////////////////////////////////////
// Single-port RAM with XOR scrambling, one cycle read latency
// Width must not exceed ScrKeyW, contents are not reset
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module scr_ram_1p import shell_pkg::*; #(
  parameter int unsigned Width = 32,
  parameter int unsigned Depth = 64
) (
  input  logic                     clk_i,
  input  logic                     req_i,
  input  logic                     write_i,
  input  logic [$clog2(Depth)-1:0] addr_i,
  input  logic [Width-1:0]         wdata_i,
  input  logic [ScrKeyW-1:0]       key_i,
  output logic [Width-1:0]         rdata_o
);

  logic [Width-1:0] mem [Depth];
  logic [Width-1:0] key_stream;
  logic [Width-1:0] rdata_q;

  // Low bits of the current key
  assign key_stream = key_i[Width-1:0];

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (write_i) begin
        mem[addr_i] <= wdata_i ^ key_stream;
      end else begin
        // Read result holds until the next read
        rdata_q <= mem[addr_i] ^ key_stream;
      end
    end
  end

  assign rdata_o = rdata_q;

endmodule

/* rtl/scramble_key_ctrl.sv */
////////////////////////////////////////////////////////////////////////////
// Scramble key request and capture
// A new key is taken on any cycle where key_valid_i is high
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module scramble_key_ctrl import shell_pkg::*; (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               key_req_i,
  input  logic               key_valid_i,
  input  logic [ScrKeyW-1:0] key_i,
  output logic               key_valid_o,
  output logic               scramble_req_o,
  output logic [ScrKeyW-1:0] key_o
);

  logic               req_d, req_q;
  logic               valid_d, valid_q;
  logic [ScrKeyW-1:0] key_q;

  // Request rises on the core pulse and holds until a key comes back
  assign req_d = req_q ? ~key_valid_i : key_req_i;

  // Key stays valid until the core asks for a new one
  assign valid_d = req_q     ? key_valid_i :
                   key_req_i ? 1'b0        :
                               valid_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_q   <= 1'b0;
      valid_q <= 1'b1;
    end else begin
      req_q   <= req_d;
      valid_q <= valid_d;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      key_q <= ScrKeyDefault;
    end else if (key_valid_i) begin
      key_q <= key_i;
    end
  end

  assign scramble_req_o = req_q;
  assign key_valid_o    = valid_q;
  assign key_o          = key_q;

endmodule

/* rtl/register_file.sv */
////////////////////////////////////////////////////////////////////////////
// Flip-flop register file, two read ports and one write port
// Runs on the gated core clock, x0 and absent registers read zero
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module register_file import shell_pkg::*; #(
  parameter bit Rv32e = 1'b0
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic [RfAddrW-1:0] raddr_a_i,
  input  logic [RfAddrW-1:0] raddr_b_i,
  input  logic [RfAddrW-1:0] waddr_i,
  input  logic               we_i,
  input  logic [RfDataW-1:0] wdata_i,
  output logic [RfDataW-1:0] rdata_a_o,
  output logic [RfDataW-1:0] rdata_b_o
);

  localparam int unsigned NumRegs  = Rv32e ? 16 : 32;
  localparam int unsigned NumSlots = 2 ** RfAddrW;

  // One slot per address, unused slots hold a constant zero
  logic [RfDataW-1:0] rf_mem [NumSlots];

  for (genvar i = 0; i < NumSlots; i++) begin : g_regs
    if (i == 0 || i >= NumRegs) begin : g_zero
      assign rf_mem[i] = '0;
    end else begin : g_flop
      logic               wr_en;
      logic [RfDataW-1:0] reg_q;

      // Write address decode for this register
      assign wr_en = we_i & (waddr_i == RfAddrW'(i));

      always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
          reg_q <= '0;
        end else if (wr_en) begin
          reg_q <= wdata_i;
        end
      end

      assign rf_mem[i] = reg_q;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Read ports
  ////////////////////////////////////////////////////////////////////////////

  assign rdata_a_o = rf_mem[raddr_a_i];
  assign rdata_b_o = rf_mem[raddr_b_i];

endmodule

/* rtl/sleep_ctrl.sv */
////////////////////////////////////////////////////////////////////////////
// Core clock gate driven by the registered busy code and wake events
// Wake events act combinationally, busy code changes one cycle late
// test_en_i forces the gated clock on without changing core_sleep_o
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module sleep_ctrl import shell_pkg::*; #(
  parameter bit SecureBusy = 1'b1
) (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       test_en_i,
  input  busy_code_t core_busy_i,
  input  logic       irq_pending_i,
  input  logic       irq_nm_i,
  input  logic       debug_req_i,
  output logic       clk_core_o,
  output logic       core_sleep_o
);

  busy_code_t busy_q;
  logic       busy;
  logic       clock_en;
  logic       en_latch;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= BusyOff;
    end else begin
      busy_q <= core_busy_i;
    end
  end

  // Secure mode keeps running unless the exact off pattern is seen
  assign busy = SecureBusy ? (busy_q != BusyOff) : busy_q[0];

  assign clock_en     = busy | debug_req_i | irq_pending_i | irq_nm_i;
  assign core_sleep_o = ~clock_en;

  // Transparent while clk_i is low so the gated clock has no glitches
  always_latch begin
    if (!clk_i) begin
      en_latch <= clock_en | test_en_i;
    end
  end

  assign clk_core_o = clk_i & en_latch;

endmodule

/* rtl/shell_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// Shared types and constants for the core wrapper
// Cache widths must not exceed the scramble key width
////////////////////////////////////////////////////////////////////////////

package shell_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Core busy signalling
  ////////////////////////////////////////////////////////////////////////////

  // Multi-bit busy code, only two values are legal encodings
  typedef logic [3:0] busy_code_t;

  parameter busy_code_t BusyOn  = 4'b0101;
  parameter busy_code_t BusyOff = 4'b1010;

  ////////////////////////////////////////////////////////////////////////////
  // Instruction cache geometry
  ////////////////////////////////////////////////////////////////////////////

  parameter int unsigned IcNumWays  = 2;
  parameter int unsigned IcNumLines = 64;
  parameter int unsigned IcIndexW   = 6;
  parameter int unsigned IcTagW     = 22;
  parameter int unsigned IcLineW    = 64;

  ////////////////////////////////////////////////////////////////////////////
  // Scrambling
  ////////////////////////////////////////////////////////////////////////////

  parameter int unsigned ScrKeyW = 64;

  // Key in use until the first key arrives, must be non-zero
  parameter logic [ScrKeyW-1:0] ScrKeyDefault = 64'h9E37_79B9_7F4A_7C15;

  ////////////////////////////////////////////////////////////////////////////
  // Register file
  ////////////////////////////////////////////////////////////////////////////

  parameter int unsigned RfAddrW = 5;
  parameter int unsigned RfDataW = 32;

endpackage
